// ==== verilog/soc_bus_pkg.sv ====
package soc_bus_pkg;

   // One master request, held steady until ready
   typedef struct packed
   {
      logic        valid;
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [3:0]  wstrb;   // Zero means read
   } bus_req_t;

   // One device response
   typedef struct packed
   {
      logic        ready;
      logic [31:0] rdata;
   } bus_rsp_t;

   // One select bit per device
   typedef struct packed
   {
      logic ram;
      logic led;
      logic uart;
      logic timer;
      logic prng;
   } dev_sel_t;

   // Address map
   localparam logic [31:0] RAM_BASE   = 32'h0000_0000;   // Low 4 KiB
   localparam logic [31:0] TIMER_ADDR = 32'hFFFF_0030;
   localparam logic [31:0] UART_ADDR  = 32'hFFFF_0040;   // Data, status at +4
   localparam logic [31:0] PRNG_ADDR  = 32'hFFFF_0050;
   localparam logic [31:0] LED_ADDR   = 32'hFFFF_0060;

   // Read value for holes in the map
   localparam logic [31:0] UNMAPPED_DATA = 32'hDEAD_BEEF;

endpackage

// ==== verilog/bus_decoder.sv ====
`timescale 1ns/1ps

module bus_decoder import soc_bus_pkg::*;
(
   input  logic     CLOCK,
   input  logic     rst_n,
   input  bus_req_t bus_req,
   output dev_sel_t sel,
   input  bus_rsp_t ram_rsp,
   input  bus_rsp_t led_rsp,
   input  bus_rsp_t uart_rsp,
   input  bus_rsp_t timer_rsp,
   input  bus_rsp_t prng_rsp,
   output bus_rsp_t bus_rsp
);

   logic hit_ram;
   logic hit_led;
   logic hit_uart;
   logic hit_timer;
   logic hit_prng;
   logic unmapped;
   logic unmapped_ready;

   // Address windows
   assign hit_ram   = bus_req.addr[31:12] == RAM_BASE[31:12];
   assign hit_led   = bus_req.addr == LED_ADDR;
   assign hit_uart  = bus_req.addr[31:3] == UART_ADDR[31:3];   // Data and status words
   assign hit_timer = bus_req.addr == TIMER_ADDR;
   assign hit_prng  = bus_req.addr == PRNG_ADDR;

   assign sel.ram   = bus_req.valid && hit_ram;
   assign sel.led   = bus_req.valid && hit_led;
   assign sel.uart  = bus_req.valid && hit_uart;
   assign sel.timer = bus_req.valid && hit_timer;
   assign sel.prng  = bus_req.valid && hit_prng;

   assign unmapped = bus_req.valid && !(hit_ram || hit_led || hit_uart || hit_timer || hit_prng);

   // Answer holes once, one cycle late, like a device would
   always_ff @(posedge CLOCK)
   begin
      if (!rst_n)
         unmapped_ready <= 1'b0;
      else
         unmapped_ready <= unmapped && !unmapped_ready;
   end

   // Select still holds while the response is up
   always_comb
   begin
      if (sel.ram)
         bus_rsp = ram_rsp;
      else if (sel.led)
         bus_rsp = led_rsp;
      else if (sel.uart)
         bus_rsp = uart_rsp;
      else if (sel.timer)
         bus_rsp = timer_rsp;
      else if (sel.prng)
         bus_rsp = prng_rsp;
      else
      begin
         bus_rsp.ready = unmapped_ready;
         bus_rsp.rdata = UNMAPPED_DATA;
      end
   end

endmodule

// ==== verilog/led_port.sv ====
`timescale 1ns/1ps

module led_port import soc_bus_pkg::*;
(
   input  logic       CLOCK,
   input  logic       rst_n,
   input  bus_req_t   bus_req,
   input  logic       sel,
   output bus_rsp_t   rsp,
   output logic [7:0] leds
);

   logic ready_q;
   logic access;

   assign access = sel && !ready_q;   // First edge of a request only

   always_ff @(posedge CLOCK)
   begin
      if (!rst_n)
      begin
         ready_q <= 1'b0;
         leds    <= 8'd0;
      end
      else
      begin
         ready_q <= access;
         if (access && bus_req.wstrb[0])
            leds <= bus_req.wdata[7:0];   // Lane 0 only
      end
   end

   assign rsp.ready = ready_q;
   assign rsp.rdata = {24'd0, leds};

endmodule

// ==== verilog/countdown_timer.sv ====
`timescale 1ns/1ps

module countdown_timer import soc_bus_pkg::*;
(
   input  logic     CLOCK,
   input  logic     rst_n,
   input  bus_req_t bus_req,
   input  logic     sel,
   output bus_rsp_t rsp
);

   logic        ready_q;
   logic        access;
   logic        write;
   logic [31:0] count;
   logic [31:0] load_value;

   assign access = sel && !ready_q;
   assign write  = access && (bus_req.wstrb != 4'd0);

   // Strobed bytes from the bus, the rest from the current count
   always_comb
   begin
      load_value = count;
      for (int i = 0; i < 4; i++)
      begin
         if (bus_req.wstrb[i])
            load_value[i*8 +: 8] = bus_req.wdata[i*8 +: 8];
      end
   end

   always_ff @(posedge CLOCK)
   begin
      if (!rst_n)
      begin
         ready_q <= 1'b0;
         count   <= 32'd0;
      end
      else
      begin
         ready_q <= access;
         if (write)
            count <= load_value;
         else if (count != 32'd0)
            count <= count - 32'd1;   // Sticks at zero
      end
   end

   assign rsp.ready = ready_q;
   assign rsp.rdata = count;

endmodule

// ==== verilog/xorshift_prng.sv ====
`timescale 1ns/1ps

module xorshift_prng import soc_bus_pkg::*;
(
   input  logic     CLOCK,
   input  logic     rst_n,
   input  bus_req_t bus_req,
   input  logic     sel,
   output bus_rsp_t rsp
);

   logic        ready_q;
   logic        access;
   logic [31:0] state;
   logic [31:0] step1;
   logic [31:0] step2;
   logic [31:0] next_state;

   assign access = sel && !ready_q;

   // xorshift32, shifts 13, 17, 5
   assign step1      = state ^ (state << 13);
   assign step2      = step1 ^ (step1 >> 17);
   assign next_state = step2 ^ (step2 << 5);

   always_ff @(posedge CLOCK)
   begin
      if (!rst_n)
      begin
         ready_q <= 1'b0;
         state   <= 32'd1;
      end
      else
      begin
         ready_q <= access;
         if (access && bus_req.wstrb != 4'd0)
            state <= (bus_req.wdata == 32'd0) ? 32'd1 : bus_req.wdata;   // Zero would lock up
         else if (access)
            state <= next_state;   // A read advances the sequence
      end
   end

   // New state is visible in the ready cycle
   assign rsp.ready = ready_q;
   assign rsp.rdata = state;

endmodule

// ==== verilog/word_ram.sv ====
`timescale 1ns/1ps

module word_ram import soc_bus_pkg::*;
#(
   parameter int RAM_WORDS = 256
)
(
   input  logic     CLOCK,
   input  bus_req_t bus_req,
   input  logic     sel,
   output bus_rsp_t rsp
);

   localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

   logic [31:0]      mem [RAM_WORDS];
   logic [IDX_W-1:0] word_idx;
   logic             ready_q;
   logic             access;
   logic [31:0]      rdata_q;

   // Word index wraps at the end of the array
   assign word_idx = IDX_W'({2'b00, bus_req.addr[31:2]} % RAM_WORDS);
   assign access   = sel && !ready_q;

   always_ff @(posedge CLOCK)
   begin
      ready_q <= access;   // Idles low once sel stays away
      if (access)
      begin
         rdata_q <= mem[word_idx];
         for (int i = 0; i < 4; i++)
         begin
            if (bus_req.wstrb[i])
               mem[word_idx][i*8 +: 8] <= bus_req.wdata[i*8 +: 8];
         end
      end
   end

   assign rsp.ready = ready_q;
   assign rsp.rdata = rdata_q;

endmodule

// ==== verilog/uart_transmitter.sv ====
`timescale 1ns/1ps

module uart_transmitter import soc_bus_pkg::*;
#(
   parameter int CLKS_PER_BIT = 16
)
(
   input  logic     CLOCK,
   input  logic     rst_n,
   input  bus_req_t bus_req,
   input  logic     sel,
   output bus_rsp_t rsp,
   output logic     uart_tx
);

   localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
   localparam logic [CNT_W-1:0] LAST_CLK = CNT_W'(CLKS_PER_BIT - 1);

   logic             ready_q;
   logic             access;
   logic             start;
   logic [31:0]      rdata_q;
   logic             busy;
   logic [9:0]       shift_q;    // Stop, data, start; bit 0 on the line
   logic [3:0]       bit_cnt;
   logic [CNT_W-1:0] clk_cnt;

   assign access = sel && !ready_q;

   // Data word write while idle; a busy write is acked and lost
   assign start = access && !bus_req.addr[2] && (bus_req.wstrb != 4'd0) && !busy;

   always_ff @(posedge CLOCK)
   begin
      if (!rst_n)
      begin
         ready_q <= 1'b0;
         rdata_q <= 32'd0;
         busy    <= 1'b0;
         shift_q <= 10'h3FF;
         bit_cnt <= 4'd0;
         clk_cnt <= '0;
      end
      else
      begin
         ready_q <= access;
         if (access)
            rdata_q <= bus_req.addr[2] ? {31'd0, busy} : 32'd0;   // Status in bit 0

         if (start)
         begin
            busy    <= 1'b1;
            shift_q <= {1'b1, bus_req.wdata[7:0], 1'b0};
            bit_cnt <= 4'd0;
            clk_cnt <= '0;
         end
         else if (busy)
         begin
            if (clk_cnt == LAST_CLK)
            begin
               clk_cnt <= '0;
               if (bit_cnt == 4'd9)
                  busy <= 1'b0;   // End of the stop bit
               else
               begin
                  shift_q <= {1'b1, shift_q[9:1]};
                  bit_cnt <= bit_cnt + 4'd1;
               end
            end
            else
               clk_cnt <= clk_cnt + 1'b1;
         end
      end
   end

   // Line idles high between frames
   assign uart_tx = busy ? shift_q[0] : 1'b1;

   assign rsp.ready = ready_q;
   assign rsp.rdata = rdata_q;

endmodule

// ==== verilog/periph_top.sv ====
`timescale 1ns/1ps

module periph_top import soc_bus_pkg::*;
#(
   parameter int RAM_WORDS    = 256,
   parameter int CLKS_PER_BIT = 16
)
(
   input  logic       CLOCK,
   input  logic       rst_n,
   input  bus_req_t   bus_req,
   output bus_rsp_t   bus_rsp,
   output logic [7:0] leds,
   output logic       uart_tx
);

   dev_sel_t sel;
   bus_rsp_t ram_rsp;
   bus_rsp_t led_rsp;
   bus_rsp_t uart_rsp;
   bus_rsp_t timer_rsp;
   bus_rsp_t prng_rsp;

   bus_decoder decoder_i (
      .CLOCK     (CLOCK),
      .rst_n     (rst_n),
      .bus_req   (bus_req),
      .sel       (sel),
      .ram_rsp   (ram_rsp),
      .led_rsp   (led_rsp),
      .uart_rsp  (uart_rsp),
      .timer_rsp (timer_rsp),
      .prng_rsp  (prng_rsp),
      .bus_rsp   (bus_rsp)
   );

   word_ram #(.RAM_WORDS(RAM_WORDS)) ram_i (
      .CLOCK   (CLOCK),
      .bus_req (bus_req),
      .sel     (sel.ram),
      .rsp     (ram_rsp)
   );

   led_port led_i (
      .CLOCK   (CLOCK),
      .rst_n   (rst_n),
      .bus_req (bus_req),
      .sel     (sel.led),
      .rsp     (led_rsp),
      .leds    (leds)
   );

   uart_transmitter #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_i (
      .CLOCK   (CLOCK),
      .rst_n   (rst_n),
      .bus_req (bus_req),
      .sel     (sel.uart),
      .rsp     (uart_rsp),
      .uart_tx (uart_tx)
   );

   countdown_timer timer_i (
      .CLOCK   (CLOCK),
      .rst_n   (rst_n),
      .bus_req (bus_req),
      .sel     (sel.timer),
      .rsp     (timer_rsp)
   );

   xorshift_prng prng_i (
      .CLOCK   (CLOCK),
      .rst_n   (rst_n),
      .bus_req (bus_req),
      .sel     (sel.prng),
      .rsp     (prng_rsp)
   );

endmodule

// ==== verification/periph_tb.sv ====
`timescale 1ns/1ps

module periph_tb import soc_bus_pkg::*; ();

   localparam int RAM_WORDS    = 256;
   localparam int CLKS_PER_BIT = 16;
   localparam int MAX_OPS      = 64;
   localparam int BUS_TIMEOUT  = 8;     // Cycles to wait for ready
   localparam int POLL_LIMIT   = 200;   // Status or count reads
   localparam logic [31:0] RAND_BASE = 32'h0000_0200;

   logic        CLOCK = 1'b0;
   logic        rst_n;
   bus_req_t    bus_req;
   bus_rsp_t    bus_rsp;
   logic [7:0]  leds;
   logic        uart_tx;

   logic [31:0] tests [0:4*MAX_OPS-1];   // Op, address, data, argument
   logic [31:0] lcg_state = 32'd7;
   int          error_count = 0;
   int          check_count = 0;

   // Serial monitor results
   logic [7:0]  rx_data [0:15];
   logic        rx_good [0:15];
   int          rx_count = 0;
   int          rx_seen  = 0;
   logic        mon_busy = 1'b0;
   logic        mon_ok;
   logic [7:0]  mon_byte;
   int          mon_cnt;

   periph_top #(.RAM_WORDS(RAM_WORDS), .CLKS_PER_BIT(CLKS_PER_BIT)) dut_i (
      .CLOCK   (CLOCK),
      .rst_n   (rst_n),
      .bus_req (bus_req),
      .bus_rsp (bus_rsp),
      .leds    (leds),
      .uart_tx (uart_tx)
   );

   always #5 CLOCK = ~CLOCK;

   // Bit k is sampled k*CLKS_PER_BIT + CLKS_PER_BIT/2 clocks after the start edge
   always @(negedge CLOCK)
   begin
      if (!mon_busy)
      begin
         if (rst_n === 1'b1 && uart_tx === 1'b0)
         begin
            mon_busy = 1'b1;
            mon_ok   = 1'b1;
            mon_cnt  = 0;
         end
      end
      else
      begin
         mon_cnt = mon_cnt + 1;
         if (mon_cnt % CLKS_PER_BIT == CLKS_PER_BIT / 2)
         begin
            if (mon_cnt < CLKS_PER_BIT)
               mon_ok = mon_ok && (uart_tx === 1'b0);   // Start bit
            else if (mon_cnt < 9 * CLKS_PER_BIT)
               mon_byte = {uart_tx, mon_byte[7:1]};   // LSB first
            else
            begin
               mon_ok = mon_ok && (uart_tx === 1'b1);   // Stop bit
               if (rx_count < 16)
               begin
                  rx_data[rx_count] = mon_byte;
                  rx_good[rx_count] = mon_ok;
               end
               rx_count = rx_count + 1;
               mon_busy = 1'b0;
            end
         end
      end
   end

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      check_count = check_count + 1;
      if (actual !== expected)
      begin
         error_count = error_count + 1;
         $display("CHECK FAILED at %0t: %s, got %08h, expected %08h",
                  $time, what, actual, expected);
      end
   endtask

   task automatic stop_on_timeout(input string what);
      $display("Timeout at %0t: %s", $time, what);
      $display("Errors: %0d in %0d checks, run stopped by a timeout", error_count, check_count);
      $display("Checks failed");
      $finish;
   endtask

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // xorshift32 step from the shift rule 13, 17, 5
   function automatic logic [31:0] xorshift_next(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] wstrb, output logic [31:0] rdata);
      int cycles;
      @(posedge CLOCK);
      bus_req.valid <= 1'b1;
      bus_req.addr  <= addr;
      bus_req.wdata <= wdata;
      bus_req.wstrb <= wstrb;
      cycles = 0;
      do
      begin
         @(posedge CLOCK);
         cycles = cycles + 1;
         @(negedge CLOCK);
      end
      while (bus_rsp.ready !== 1'b1 && cycles < BUS_TIMEOUT);
      if (bus_rsp.ready !== 1'b1)
         stop_on_timeout($sformatf("no ready for address %08h", addr));
      else
      begin
         check_value(32'(cycles), 32'd1, $sformatf("ready latency at %08h", addr));
         rdata = bus_rsp.rdata;
         @(posedge CLOCK);
         bus_req.valid <= 1'b0;   // Dropped on the edge that sees ready
      end
   endtask

   task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb);
      logic [31:0] unused;
      bus_access(addr, wdata, wstrb, unused);
   endtask

   task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
      bus_access(addr, 32'd0, 4'd0, rdata);
   endtask

   task automatic wait_uart_idle();
      logic [31:0] status;
      int          polls;
      status = 32'd1;
      polls  = 0;
      while (status[0] !== 1'b0 && polls < POLL_LIMIT)
      begin
         bus_read(UART_ADDR + 32'd4, status);
         polls = polls + 1;
      end
      if (status[0] !== 1'b0)
         stop_on_timeout("serial transmitter stays busy");
   endtask

   task automatic send_serial_byte(input logic [7:0] b);
      logic [31:0] status;
      wait_uart_idle();
      bus_write(UART_ADDR, {24'd0, b}, 4'h1);
      bus_read(UART_ADDR + 32'd4, status);
      check_value(status, 32'd1, "busy after a data write");
      bus_write(UART_ADDR, {24'd0, ~b}, 4'h1);   // Must be dropped
      wait_uart_idle();
      check_value(32'(rx_count - rx_seen), 32'd1, "frames for one written byte");
      if (rx_count > rx_seen && rx_seen < 16)
      begin
         check_value(32'(rx_data[rx_seen]), 32'(b), "decoded serial byte");
         check_value(32'(rx_good[rx_seen]), 32'd1, "serial start and stop bits");
      end
      rx_seen = rx_count;
   endtask

   task automatic run_prng(input logic [31:0] seed, input int reads);
      logic [31:0] model;
      logic [31:0] value;
      bus_write(PRNG_ADDR, seed, 4'hF);
      model = (seed == 32'd0) ? 32'd1 : seed;   // Zero seed restarts from 1
      for (int i = 0; i < reads; i++)
      begin
         model = xorshift_next(model);
         bus_read(PRNG_ADDR, value);
         check_value(value, model, "PRNG sequence");
      end
   endtask

   task automatic run_timer(input logic [31:0] load);
      logic [31:0] value;
      logic [31:0] prev;
      int          polls;
      bus_write(TIMER_ADDR, load, 4'hF);
      prev  = load;
      value = load;
      polls = 0;
      while (value != 32'd0 && polls < POLL_LIMIT)
      begin
         bus_read(TIMER_ADDR, value);
         check_value(32'(value > prev), 32'd0, "timer count went up");
         if (polls == 0)
            check_value(32'(value != 32'd0), 32'd1, "timer count after load");
         prev  = value;
         polls = polls + 1;
      end
      if (value != 32'd0)
         stop_on_timeout("timer never reached zero");
      else
      begin
         for (int i = 0; i < 2; i++)
         begin
            bus_read(TIMER_ADDR, value);
            check_value(value, 32'd0, "timer held at zero");
         end
      end
   endtask

   task automatic run_ram_random(input int count);
      logic [31:0] model [16];
      logic [31:0] rnd;
      logic [31:0] addr;
      logic [31:0] data;
      logic [3:0]  idx;
      logic [3:0]  strb;
      // Full words first so that every byte has a known value
      for (int i = 0; i < 16; i++)
      begin
         model[i] = lcg_next();
         bus_write(RAND_BASE + 32'(i) * 4, model[i], 4'hF);
      end
      for (int n = 0; n < count; n++)
      begin
         rnd  = lcg_next() >> 12;
         idx  = rnd[3:0];
         strb = (rnd[7:4] == 4'd0) ? 4'hF : rnd[7:4];
         addr = {20'd0, rnd[9:8], 10'd0} + RAND_BASE + {26'd0, idx, 2'b00};   // 1 KiB aliases
         data = lcg_next();
         for (int b = 0; b < 4; b++)
         begin
            if (strb[b])
               model[idx][b*8 +: 8] = data[b*8 +: 8];
         end
         bus_write(addr, data, strb);
      end
      for (int i = 0; i < 16; i++)
      begin
         bus_read(RAND_BASE + 32'(i) * 4, data);
         check_value(data, model[i], $sformatf("RAM word %0d after random writes", i));
      end
   endtask

   initial
   begin
      int          pc;
      logic        done;
      logic [31:0] op;
      logic [31:0] addr;
      logic [31:0] data;
      logic [31:0] arg;
      logic [31:0] value;
      rst_n   = 1'b0;
      bus_req = '0;
      $readmemh("verification/periph_tests.txt", tests);
      repeat (4) @(posedge CLOCK);
      rst_n <= 1'b1;
      @(negedge CLOCK);
      check_value(32'(bus_rsp.ready), 32'd0, "ready after reset");
      check_value(32'(leds), 32'd0, "leds after reset");
      check_value(32'(uart_tx), 32'd1, "serial line after reset");

      pc   = 0;
      done = 1'b0;
      while (!done && pc < MAX_OPS)
      begin
         op   = tests[4*pc];
         addr = tests[4*pc + 1];
         data = tests[4*pc + 2];
         arg  = tests[4*pc + 3];
         case (op)
            32'd0: done = 1'b1;
            32'd1: bus_write(addr, data, arg[3:0]);
            32'd2:
            begin
               bus_read(addr, value);
               check_value(value, data, $sformatf("read of %08h", addr));
            end
            32'd3: send_serial_byte(data[7:0]);
            32'd4: run_prng(data, int'(arg));
            32'd5: run_timer(data);
            32'd6: run_ram_random(int'(arg));
            32'd7: check_value(32'(leds), data, "leds pins");
            default:
            begin
               error_count = error_count + 1;
               $display("Unknown operation %08h on test line %0d", op, pc);
               done = 1'b1;
            end
         endcase
         pc = pc + 1;
      end

      $display("Errors: %0d in %0d checks", error_count, check_count);
      if (error_count == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

// ==== verification/periph_tests.txt ====
// Columns: op address data argument. op 1 write (argument = strobe), 2 read (data = expected),
// 3 serial byte, 4 PRNG seed (argument = reads), 5 timer load, 6 random RAM writes, 7 leds, 0 end
00000001 00000010 11223344 0000000F
00000001 00000010 AABBCCDD 00000005
00000002 00000010 11BB33DD 00000000
00000001 00000414 55667788 0000000F
00000001 00000014 0000EE00 00000002
00000002 00000C14 5566EE88 00000000
00000002 00000014 5566EE88 00000000
00000006 00000000 00000000 00000040
00000002 FFFF0060 00000000 00000000
00000001 FFFF0060 000000A5 00000001
00000007 00000000 000000A5 00000000
00000002 FFFF0060 000000A5 00000000
00000001 FFFF0060 0000003C 0000000E
00000002 FFFF0060 000000A5 00000000
00000007 00000000 000000A5 00000000
00000002 FFFF0044 00000000 00000000
00000003 00000000 00000055 00000000
00000003 00000000 000000C3 00000000
00000003 00000000 00000001 00000000
00000004 00000000 12345678 00000004
00000004 00000000 00000000 00000003
00000005 00000000 000000C8 00000000
00000002 FFFF0070 DEADBEEF 00000000
00000002 00002000 DEADBEEF 00000000
00000001 FFFF0080 00000000 0000000F
00000002 FFFF0048 DEADBEEF 00000000
00000000 00000000 00000000 00000000

// ==== filelist.f ====
verilog/soc_bus_pkg.sv
verilog/bus_decoder.sv
verilog/led_port.sv
verilog/countdown_timer.sv
verilog/xorshift_prng.sv
verilog/word_ram.sv
verilog/uart_transmitter.sv
verilog/periph_top.sv
verification/periph_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the peripheral bus testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module periph_tb -o periph_sim
output=$(./obj_dir/periph_sim)
echo "$output"

if echo "$output" | grep -qx "All checks passed"; then
   exit 0
fi
exit 1
